// File: files.f
logic/eth_tx_pkg.sv
logic/frame_byte_if.sv
logic/eth_tx_sequencer.sv
logic/payload_fifo.sv
logic/crc32_gen.sv
logic/gmii_byte_mux.sv
logic/eth_tx_top.sv
bench/eth_tx_properties.sv
bench/eth_tx_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the eth_tx testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module eth_tx_tb \
	-Mdir obj_dir -f files.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

# keep running past assertion errors so the testbench can print its report
out=$(./obj_dir/Veth_tx_tb +verilator+error+limit+100)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "Simulation completed successfully"; then
	exit 0
fi
exit 1

// File: bench/eth_tx_tb.sv
module eth_tx_tb import eth_tx_pkg::*; ();

	localparam int FIFO_DEPTH = 16;
	localparam int IFG_CYCLES = 12;
	localparam int NUM_FRAMES = 6;
	// every frame counted at full length, twice over
	localparam int MAX_CYCLES = 2 * NUM_FRAMES * (26 + FIFO_DEPTH + IFG_CYCLES + 10);

	logic        gmii_tx_clk = 1'b0;
	logic        rst_n;
	logic        tx_req;
	logic        tx_ack;
	logic [47:0] dest_mac;
	logic [47:0] src_mac;
	logic [15:0] type_length;
	logic [15:0] data_length;
	logic        wr_en;
	logic [7:0]  wr_data;
	logic        fifo_full;
	logic        gmii_tx_en;
	logic        gmii_tx_er;
	logic [7:0]  gmii_tx_data;

	logic [31:0] lfsr = 32'hd9a3_2802;
	logic [7:0]  exp_q[$];    // expected gmii bytes
	logic        exp_er_q[$];
	int          len_q[$];    // expected tx_en run lengths
	int          mismatches = 0;
	int          other_fails = 0;
	int          cycles = 0;
	int          run_len = 0;
	int          idle_len = 0;
	int          frames_seen = 0;

	eth_tx_top #(
		.FIFO_DEPTH(FIFO_DEPTH),
		.IFG_CYCLES(IFG_CYCLES)
	) eth_tx_top_inst (
		.gmii_tx_clk (gmii_tx_clk),
		.rst_n       (rst_n),
		.tx_req      (tx_req),
		.tx_ack      (tx_ack),
		.dest_mac    (dest_mac),
		.src_mac     (src_mac),
		.type_length (type_length),
		.data_length (data_length),
		.wr_en       (wr_en),
		.wr_data     (wr_data),
		.fifo_full   (fifo_full),
		.gmii_tx_en  (gmii_tx_en),
		.gmii_tx_er  (gmii_tx_er),
		.gmii_tx_data(gmii_tx_data)
	);

	always #4 gmii_tx_clk = ~gmii_tx_clk;

	// fibonacci lfsr, taps 32 22 2 1, one step per bit
	function automatic logic [31:0] lfsr_bits(input int n);
		logic [31:0] r;
		logic        fb;
		r = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			r = {r[30:0], fb};
		end
		return r;
	endfunction

	// whole frame from preamble to fcs
	function automatic void build_frame(input logic [47:0] dst, input logic [47:0] src,
			input logic [15:0] tl, input logic [7:0] pay[$], output logic [7:0] fr[$]);
		logic [31:0] c;
		logic        fbit;
		fr = {};
		repeat (7) fr.push_back(8'h55);
		fr.push_back(8'hd5);
		for (int i = 5; i >= 0; i--)
			fr.push_back(dst[8*i +: 8]);
		for (int i = 5; i >= 0; i--)
			fr.push_back(src[8*i +: 8]);
		fr.push_back(tl[15:8]);
		fr.push_back(tl[7:0]);
		foreach (pay[i])
			fr.push_back(pay[i]);
		c = CRC_INIT;
		for (int i = 8; i < fr.size(); i++) begin // crc starts after the sfd
			for (int b = 0; b < 8; b++) begin
				fbit = c[0] ^ fr[i][b];
				c = c >> 1;
				if (fbit)
					c = c ^ CRC_POLY;
			end
		end
		c = ~c;
		for (int i = 0; i < 4; i++)
			fr.push_back(c[8*i +: 8]); // low byte first
	endfunction

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			mismatches++;
			$display("ERROR at %0t: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	// n payload bytes requested, n_wr bytes pushed beforehand
	task automatic send_frame(input int n, input int n_wr);
		logic [7:0] pay[$];
		logic [7:0] fr[$];
		int         acc;
		acc = 0;
		for (int i = 0; i < n_wr; i++) begin
			@(negedge gmii_tx_clk);
			compare("fifo_full", 32'(fifo_full), 32'(acc == FIFO_DEPTH));
			wr_en = 1'b1;
			wr_data = 8'(lfsr_bits(8));
			if (acc < FIFO_DEPTH) begin // extra writes get dropped
				pay.push_back(wr_data);
				acc++;
			end
		end
		@(negedge gmii_tx_clk);
		wr_en = 1'b0;
		compare("fifo_full", 32'(fifo_full), 32'(acc == FIFO_DEPTH));
		while (pay.size() < n)
			pay.push_back(8'h00); // underrun fill
		dest_mac[47:32] = 16'(lfsr_bits(16));
		dest_mac[31:0] = lfsr_bits(32);
		src_mac[47:32] = 16'(lfsr_bits(16));
		src_mac[31:0] = lfsr_bits(32);
		type_length = 16'(lfsr_bits(16));
		build_frame(dest_mac, src_mac, type_length, pay, fr);
		foreach (fr[i]) begin
			exp_q.push_back(fr[i]);
			exp_er_q.push_back((i >= 22 + acc) && (i < 22 + n));
		end
		len_q.push_back(26 + n);
		data_length = 16'(n);
		tx_req = 1'b1;
		while (!tx_ack)
			@(negedge gmii_tx_clk);
		compare("gmii_tx_en", 32'(gmii_tx_en), 32'd0);
		if (exp_q.size() != 0) begin
			other_fails++;
			$display("tx_ack rose with %0d frame bytes still not sent", exp_q.size());
		end
		repeat (3) begin // req held, nothing new may start
			@(negedge gmii_tx_clk);
			compare("tx_ack", 32'(tx_ack), 32'd1);
			compare("gmii_tx_en", 32'(gmii_tx_en), 32'd0);
		end
		tx_req = 1'b0;
		@(negedge gmii_tx_clk);
		compare("tx_ack", 32'(tx_ack), 32'd0);
	endtask

	always @(negedge gmii_tx_clk) begin
		if (rst_n) begin
			if (gmii_tx_en) begin
				if (run_len == 0 && frames_seen > 0 && idle_len < IFG_CYCLES) begin
					other_fails++;
					$display("only %0d idle cycles before frame %0d", idle_len, frames_seen + 1);
				end
				run_len++;
				idle_len = 0;
				if (exp_q.size() == 0) begin
					other_fails++;
					$display("gmii_tx_en high at %0t with no byte expected", $time);
				end else begin
					compare("gmii_tx_data", 32'(gmii_tx_data), 32'(exp_q.pop_front()));
					compare("gmii_tx_er", 32'(gmii_tx_er), 32'(exp_er_q.pop_front()));
				end
			end else begin
				if (run_len != 0 && len_q.size() != 0)
					compare("gmii_tx_en length", 32'(run_len), 32'(len_q.pop_front()));
				if (run_len != 0)
					frames_seen++;
				run_len = 0;
				idle_len++;
				if (gmii_tx_er) begin
					other_fails++;
					$display("gmii_tx_er high at %0t while gmii_tx_en is low", $time);
				end
			end
		end
	end

	always @(posedge gmii_tx_clk) begin
		cycles++;
		if (cycles > MAX_CYCLES) begin
			$display("timeout after %0d cycles, the DUT stopped responding", cycles);
			$display("Simulation failed");
			$finish;
		end
	end

	initial begin
		int n;
		int asserts;
		rst_n = 1'b0;
		tx_req = 1'b0;
		dest_mac = '0;
		src_mac = '0;
		type_length = '0;
		data_length = '0;
		wr_en = 1'b0;
		wr_data = '0;
		repeat (2) @(negedge gmii_tx_clk);
		rst_n = 1'b1;
		@(negedge gmii_tx_clk);
		compare("tx_ack", 32'(tx_ack), 32'd0);
		compare("gmii_tx_en", 32'(gmii_tx_en), 32'd0);
		compare("gmii_tx_data", 32'(gmii_tx_data), 32'd0);
		n = 1 + int'(lfsr_bits(8)) % FIFO_DEPTH;
		send_frame(n, n);
		send_frame(1, 1);
		send_frame(10, 4);              // partial underrun
		send_frame(5, 0);               // all underrun, requested right after ack
		n = 1 + int'(lfsr_bits(8)) % FIFO_DEPTH;
		send_frame(n, n);
		send_frame(FIFO_DEPTH, FIFO_DEPTH + 3);
		repeat (4) @(negedge gmii_tx_clk);
		compare("frames sent", 32'(frames_seen), 32'(NUM_FRAMES));
		asserts = eth_tx_top_inst.eth_tx_sequencer_inst.eth_tx_properties_inst.fail_count;
		$display("errors: %0d mismatches, %0d other failures, %0d assertion failures",
			mismatches, other_fails, asserts);
		if (mismatches == 0 && other_fails == 0 && asserts == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// File: bench/eth_tx_properties.sv
module eth_tx_properties import eth_tx_pkg::*; (
	input logic        gmii_tx_clk,
	input logic        rst_n,
	input logic        tx_req,
	input logic        tx_ack,
	input seq_state_t  state,
	input byte_field_t field
);

	int fail_count = 0; // read by the testbench report

	// ack only ever answers a pending request
	ack_needs_req: assert property (@(posedge gmii_tx_clk) disable iff (!rst_n)
		$rose(tx_ack) |-> tx_req)
	else begin
		$error("tx_ack rose while tx_req was low");
		fail_count++;
	end

	idle_until_req: assert property (@(posedge gmii_tx_clk) disable iff (!rst_n)
		(field == F_IDLE) && !(state == S_IDLE && tx_req) |=> (field == F_IDLE))
	else begin
		$error("field left F_IDLE without an accepted request");
		fail_count++;
	end

	no_frame_during_ack: assert property (@(posedge gmii_tx_clk) disable iff (!rst_n)
		tx_ack |-> (field == F_IDLE))
	else begin
		$error("frame active while tx_ack is high");
		fail_count++;
	end

endmodule

bind eth_tx_sequencer eth_tx_properties eth_tx_properties_inst (
	.gmii_tx_clk(gmii_tx_clk),
	.rst_n      (rst_n),
	.tx_req     (tx_req),
	.tx_ack     (tx_ack),
	.state      (state),
	.field      (field)
);

// File: logic/eth_tx_top.sv
module eth_tx_top #(
	parameter int FIFO_DEPTH = 64,
	parameter int IFG_CYCLES = 12
) (
	input  logic        gmii_tx_clk,
	input  logic        rst_n,
	input  logic        tx_req,
	output logic        tx_ack,
	input  logic [47:0] dest_mac,
	input  logic [47:0] src_mac,
	input  logic [15:0] type_length,
	input  logic [15:0] data_length,
	input  logic        wr_en,
	input  logic [7:0]  wr_data,
	output logic        fifo_full,
	output logic        gmii_tx_en,
	output logic        gmii_tx_er,
	output logic [7:0]  gmii_tx_data
);

	logic        fifo_pop;
	logic        fifo_empty;
	logic [7:0]  fifo_rd_data;
	logic        crc_en;
	logic [31:0] crc;
	logic [7:0]  next_byte;

	frame_byte_if fb ();

	eth_tx_sequencer #(
		.IFG_CYCLES(IFG_CYCLES)
	) eth_tx_sequencer_inst (
		.gmii_tx_clk(gmii_tx_clk),
		.rst_n      (rst_n),
		.tx_req     (tx_req),
		.tx_ack     (tx_ack),
		.data_length(data_length),
		.fifo_empty (fifo_empty),
		.fifo_pop   (fifo_pop),
		.crc_en     (crc_en),
		.fb         (fb.seq)
	);

	payload_fifo #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) payload_fifo_inst (
		.gmii_tx_clk(gmii_tx_clk),
		.rst_n      (rst_n),
		.wr_en      (wr_en),
		.wr_data    (wr_data),
		.full       (fifo_full),
		.pop        (fifo_pop),
		.rd_data    (fifo_rd_data),
		.empty      (fifo_empty)
	);

	// crc sees the same byte the mux is about to register
	crc32_gen crc32_gen_inst (
		.gmii_tx_clk(gmii_tx_clk),
		.rst_n      (rst_n),
		.init       (fb.start),
		.en         (crc_en),
		.data       (next_byte),
		.crc        (crc)
	);

	gmii_byte_mux gmii_byte_mux_inst (
		.gmii_tx_clk (gmii_tx_clk),
		.rst_n       (rst_n),
		.fb          (fb.mux),
		.dest_mac    (dest_mac),
		.src_mac     (src_mac),
		.type_length (type_length),
		.fifo_data   (fifo_rd_data),
		.crc         (crc),
		.next_byte   (next_byte),
		.gmii_tx_en  (gmii_tx_en),
		.gmii_tx_er  (gmii_tx_er),
		.gmii_tx_data(gmii_tx_data)
	);

endmodule

// File: logic/gmii_byte_mux.sv
module gmii_byte_mux import eth_tx_pkg::*; (
	input  logic        gmii_tx_clk,
	input  logic        rst_n,
	frame_byte_if.mux   fb,
	input  logic [47:0] dest_mac,
	input  logic [47:0] src_mac,
	input  logic [15:0] type_length,
	input  logic [7:0]  fifo_data,
	input  logic [31:0] crc,
	output logic [7:0]  next_byte,
	output logic        gmii_tx_en,
	output logic        gmii_tx_er,
	output logic [7:0]  gmii_tx_data
);

	logic [47:0] dest_q;
	logic [47:0] src_q;
	logic [15:0] type_q;
	logic [31:0] fcs;

	assign fcs = ~crc; // sent low byte first

	// header copy taken while the host still holds the request
	always_ff @(posedge gmii_tx_clk) begin
		if (fb.start) begin
			dest_q <= dest_mac;
			src_q  <= src_mac;
			type_q <= type_length;
		end
	end

	always_comb begin
		case (fb.field)
			F_PREAMBLE: next_byte = PREAMBLE_BYTE;
			F_SFD: next_byte = SFD_BYTE;
			F_DEST: next_byte = dest_q[8*(5 - int'(fb.byte_idx)) +: 8]; // msb first
			F_SRC: next_byte = src_q[8*(5 - int'(fb.byte_idx)) +: 8];
			F_TYPE: next_byte = type_q[8*(1 - int'(fb.byte_idx)) +: 8];
			F_PAYLOAD: next_byte = fb.underrun ? 8'h00 : fifo_data;
			F_FCS: next_byte = fcs[8*int'(fb.byte_idx) +: 8];
			default: next_byte = 8'h00;
		endcase
	end

	always_ff @(posedge gmii_tx_clk or negedge rst_n) begin
		if (!rst_n) begin
			gmii_tx_en   <= 1'b0;
			gmii_tx_er   <= 1'b0;
			gmii_tx_data <= 8'h00;
		end else begin
			gmii_tx_en   <= (fb.field != F_IDLE);
			gmii_tx_er   <= fb.underrun;  // only ever set in payload
			gmii_tx_data <= next_byte;
		end
	end

endmodule

// File: logic/crc32_gen.sv
module crc32_gen import eth_tx_pkg::*; (
	input  logic        gmii_tx_clk,
	input  logic        rst_n,
	input  logic        init,
	input  logic        en,
	input  logic [7:0]  data,
	output logic [31:0] crc
);

	logic [31:0] crc_next;

	// lsb-first, one bit per step
	always_comb begin
		crc_next = crc ^ {24'd0, data};
		for (int i = 0; i < 8; i++) begin
			if (crc_next[0])
				crc_next = (crc_next >> 1) ^ CRC_POLY;
			else
				crc_next = crc_next >> 1;
		end
	end

	always_ff @(posedge gmii_tx_clk or negedge rst_n) begin
		if (!rst_n)
			crc <= CRC_INIT;
		else if (init)
			crc <= CRC_INIT; // new frame
		else if (en)
			crc <= crc_next;
	end

endmodule

// File: logic/payload_fifo.sv
module payload_fifo #(
	parameter int FIFO_DEPTH = 64
) (
	input  logic       gmii_tx_clk,
	input  logic       rst_n,
	input  logic       wr_en,
	input  logic [7:0] wr_data,
	output logic       full,
	input  logic       pop,
	output logic [7:0] rd_data,
	output logic       empty
);

	localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	logic [7:0]       mem [FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             do_wr;
	logic             do_rd;

	assign full  = (count == CNT_W'(FIFO_DEPTH));
	assign empty = (count == '0);
	assign do_wr = wr_en && !full;  // writes while full are dropped
	assign do_rd = pop && !empty;

	assign rd_data = mem[rd_ptr]; // show-ahead, head byte always visible

	always_ff @(posedge gmii_tx_clk) begin
		if (do_wr)
			mem[wr_ptr] <= wr_data;
	end

	always_ff @(posedge gmii_tx_clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({do_wr, do_rd})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count; // both or neither
			endcase
		end
	end

endmodule

// File: logic/eth_tx_sequencer.sv
module eth_tx_sequencer import eth_tx_pkg::*; #(
	parameter int IFG_CYCLES = 12
) (
	input  logic        gmii_tx_clk,
	input  logic        rst_n,
	input  logic        tx_req,
	output logic        tx_ack,
	input  logic [15:0] data_length,
	input  logic        fifo_empty,
	output logic        fifo_pop,
	output logic        crc_en,
	frame_byte_if.seq   fb
);

	localparam int GAP_W = (IFG_CYCLES > 1) ? $clog2(IFG_CYCLES) : 1;

	seq_state_t  state;
	byte_field_t field;
	logic [2:0]  idx;
	logic [15:0] remain;  // payload bytes still to send
	logic [GAP_W-1:0] gap_cnt;
	logic        start_q;
	logic        field_done; // last byte of the current field

	assign fb.field    = field;
	assign fb.byte_idx = idx;
	assign fb.start    = start_q;

	// pop whenever a payload byte is available, otherwise flag it
	assign fifo_pop    = (field == F_PAYLOAD) && !fifo_empty;
	assign fb.underrun = (field == F_PAYLOAD) && fifo_empty;

	assign crc_en = (field == F_DEST) || (field == F_SRC) ||
	                (field == F_TYPE) || (field == F_PAYLOAD);

	always_comb begin
		case (field)
			F_PREAMBLE: field_done = (idx == 3'(PREAMBLE_LEN - 1));
			F_SFD: field_done = 1'b1;
			F_DEST, F_SRC: field_done = (idx == 3'd5); // 6 byte mac
			F_TYPE: field_done = (idx == 3'd1);
			F_PAYLOAD: field_done = (remain == 16'd1);
			F_FCS: field_done = (idx == 3'd3);
			default: field_done = 1'b0;
		endcase
	end

	always_ff @(posedge gmii_tx_clk or negedge rst_n) begin
		if (!rst_n) begin
			state   <= S_IDLE;
			field   <= F_IDLE;
			idx     <= '0;
			remain  <= '0;
			gap_cnt <= '0;
			start_q <= 1'b0;
			tx_ack  <= 1'b0;
		end else begin
			start_q <= 1'b0;
			case (state)
				S_IDLE: begin
					if (tx_req) begin
						state   <= S_FRAME;
						field   <= F_PREAMBLE;
						idx     <= '0;
						remain  <= data_length; // held stable by host
						start_q <= 1'b1;
					end
				end
				S_FRAME: begin
					if (field == F_PAYLOAD)
						remain <= remain - 16'd1;
					if (field_done) begin
						idx <= '0;
						if (field == F_FCS) begin
							field   <= F_IDLE;
							state   <= S_GAP;
							gap_cnt <= '0;
						end else begin
							field <= byte_field_t'(field + 3'd1);
						end
					end else begin
						idx <= idx + 3'd1;
					end
				end
				S_GAP: begin
					if (gap_cnt == GAP_W'(IFG_CYCLES - 1)) begin
						state  <= S_ACK;
						tx_ack <= 1'b1;
					end else begin
						gap_cnt <= gap_cnt + 1'b1;
					end
				end
				S_ACK: begin
					if (!tx_req) begin // four-phase completes here
						state  <= S_IDLE;
						tx_ack <= 1'b0;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

endmodule

// File: logic/frame_byte_if.sv
interface frame_byte_if import eth_tx_pkg::*; ();

	byte_field_t field;    // current part of the frame
	logic [2:0]  byte_idx; // byte within header / fcs field
	logic        underrun; // payload byte missing from fifo
	logic        start;    // first preamble cycle

	modport seq (
		output field,
		output byte_idx,
		output underrun,
		output start
	);

	modport mux (
		input field,
		input byte_idx,
		input underrun,
		input start
	);

endinterface

// File: logic/eth_tx_pkg.sv
package eth_tx_pkg;

	// which part of the frame is on the wire
	// F_IDLE..F_FCS are in transmit order, the sequencer steps through them
	typedef enum logic [2:0] {
		F_IDLE,
		F_PREAMBLE,
		F_SFD,
		F_DEST,
		F_SRC,
		F_TYPE,
		F_PAYLOAD,
		F_FCS
	} byte_field_t;

	typedef enum logic [1:0] {
		S_IDLE,  // waiting for tx_req
		S_FRAME, // bytes going out
		S_GAP,   // inter-frame gap
		S_ACK    // ack high, waiting for req low
	} seq_state_t;

	localparam logic [7:0] PREAMBLE_BYTE = 8'h55;
	localparam logic [7:0] SFD_BYTE = 8'hd5;
	localparam int PREAMBLE_LEN = 7;

	// reflected ieee 802.3 polynomial
	localparam logic [31:0] CRC_POLY = 32'hedb88320;
	localparam logic [31:0] CRC_INIT = 32'hffff_ffff;

endpackage
